/* source/act_settings.svh */
`ifndef ACT_SETTINGS_SVH
`define ACT_SETTINGS_SVH

// ==============================
// activation buffer sizes
// ==============================

// one buffer word as seen on the write port
`define ACT_PORT_WIDTH 64

// one activation element
`define ACT_DATA_WIDTH 8

// 32 words of activation storage
`define ACT_ADDR_WIDTH 5

// patch length field, counted in words
`define ACT_LEN_WIDTH 8

`endif

/* source/act_pkg.sv */
`include "act_settings.svh"

package act_pkg;

    // ==============================
    // derived sizes
    // ==============================
    localparam int ACT_ELEMS = `ACT_PORT_WIDTH / `ACT_DATA_WIDTH;
    localparam int ACT_DEPTH = 1 << `ACT_ADDR_WIDTH;

    // ==============================
    // data types
    // ==============================
    typedef logic [`ACT_DATA_WIDTH-1:0] act_elem_t;
    // element 0 sits in the top byte
    typedef logic [`ACT_PORT_WIDTH-1:0] act_word_t;
    typedef logic [`ACT_ADDR_WIDTH-1:0] act_addr_t;
    typedef logic [`ACT_LEN_WIDTH-1:0] act_len_t;

    // external writer port
    typedef struct packed {
        logic      en;
        act_addr_t addr;
        act_word_t data;
    } gbf_wr_t;

    // element stream to the consumer
    typedef struct packed {
        logic      rdy;
        act_elem_t data;
    } act_out_t;

    // patch controller
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CFG,
        ST_RUN,
        ST_DONE
    } patch_state_e;

endpackage

/* source/act_cfg_regs.sv */
module act_cfg_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_val,
    input  logic              cfg_req,
    input  act_pkg::act_len_t cfg_word,
    output act_pkg::act_len_t cfg_len
);

    import act_pkg::*;

    // ==============================
    // configuration capture
    // ==============================

    // patch length in words
    act_len_t len_q;
    logic     capture;

    // only accepted while the controller is asking for it
    assign capture = cfg_val && cfg_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_q <= '0;
        end else if (capture) begin
            len_q <= cfg_word;
        end
    end

    // held for the whole patch
    assign cfg_len = len_q;

endmodule

/* source/act_patch_ctrl.sv */
`include "act_settings.svh"

module act_patch_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_val,
    input  act_pkg::act_len_t cfg_len,
    input  logic              get_act,
    input  logic              act_rdy,
    output logic              cfg_req,
    output logic              patch_rst,
    output logic              patch_done
);

    import act_pkg::*;

    // element count needs room for length times elements per word
    localparam int SHIFT = $clog2(ACT_ELEMS);
    localparam int CNT_W = `ACT_LEN_WIDTH + SHIFT;

    patch_state_e     state_q;
    patch_state_e     state_d;
    logic [CNT_W-1:0] elem_cnt_q;
    logic [CNT_W-1:0] elem_nxt;
    logic [CNT_W-1:0] target;
    logic             consume;
    logic             last_elem;

    // ==============================
    // element accounting
    // ==============================
    assign consume   = get_act && act_rdy;
    assign target    = CNT_W'(cfg_len) << SHIFT;
    assign elem_nxt  = elem_cnt_q + 1'b1;
    assign last_elem = (elem_nxt == target);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_cnt_q <= '0;
        end else if (state_q == ST_DONE) begin
            elem_cnt_q <= '0;
        end else if (state_q == ST_RUN && consume) begin
            elem_cnt_q <= elem_nxt;
        end
    end

    // ==============================
    // patch FSM
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: state_d = ST_CFG;
            ST_CFG: begin
                if (cfg_val) begin
                    state_d = ST_RUN;
                end
            end
            ST_RUN: begin
                if (consume && last_elem) begin
                    state_d = ST_DONE;
                end
            end
            // single cycle, then ask for the next config
            ST_DONE: state_d = ST_CFG;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign cfg_req    = (state_q == ST_CFG);
    assign patch_done = (state_q == ST_DONE);
    // clears read address and fill count for the next patch
    assign patch_rst  = (state_q == ST_DONE);

endmodule

/* source/act_gbf.sv */
`include "act_settings.svh"

module act_gbf (
    input  logic               clk,
    input  logic               rst_n,
    input  act_pkg::gbf_wr_t   wr,
    input  logic               patch_rst,
    input  logic               rd_en,
    input  act_pkg::act_addr_t rd_addr,
    output act_pkg::act_word_t rd_data,
    output logic               avail
);

    import act_pkg::*;

    act_word_t                mem [ACT_DEPTH];
    // one extra bit so a full buffer is distinct from empty
    logic [`ACT_ADDR_WIDTH:0] fill_q;

    // ==============================
    // single port memory
    // ==============================

    // write wins the port; rd_en is never raised during a write
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // ==============================
    // unread word count
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_q <= '0;
        end else if (patch_rst) begin
            // a write landing on the clear cycle still counts
            fill_q <= wr.en ? 1'b1 : 1'b0;
        end else if (wr.en && !rd_en) begin
            fill_q <= fill_q + 1'b1;
        end else if (rd_en && !wr.en) begin
            fill_q <= fill_q - 1'b1;
        end
    end

    // port is busy whenever the writer uses it
    assign avail = (fill_q != '0) && !wr.en;

endmodule

/* source/act_fetch_unpack.sv */
`include "act_settings.svh"

module act_fetch_unpack (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               patch_rst,
    input  logic               avail,
    input  act_pkg::act_word_t rd_data,
    input  logic               get_act,
    output logic               rd_en,
    output act_pkg::act_addr_t rd_addr,
    output act_pkg::act_out_t  act
);

    import act_pkg::*;

    localparam int LEFT_W = $clog2(ACT_ELEMS + 1);

    act_word_t         shift_q;
    logic [LEFT_W-1:0] left_q;
    logic              rd_vld_q;
    logic              take;
    logic              empty;

    assign empty = (left_q == '0);
    assign take  = get_act && act.rdy;

    // ==============================
    // fetch
    // ==============================

    // one word at a time, only once the unpacker has drained
    assign rd_en = avail && empty && !rd_vld_q && !patch_rst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (patch_rst) begin
            rd_addr <= '0;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // memory data is valid the cycle after rd_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q <= 1'b0;
        end else if (patch_rst) begin
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= rd_en;
        end
    end

    // ==============================
    // unpacker
    // ==============================

    // leftmost element first, so shift toward the top
    always_ff @(posedge clk) begin
        if (rd_vld_q) begin
            shift_q <= rd_data;
        end else if (take) begin
            shift_q <= shift_q << `ACT_DATA_WIDTH;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
        end else if (patch_rst) begin
            left_q <= '0;
        end else if (rd_vld_q) begin
            left_q <= LEFT_W'(ACT_ELEMS);
        end else if (take) begin
            left_q <= left_q - 1'b1;
        end
    end

    // holds while the consumer is not pulling
    assign act.rdy  = !empty;
    assign act.data = shift_q[`ACT_PORT_WIDTH-1 -: `ACT_DATA_WIDTH];

endmodule

/* source/act_buffer_top.sv */
module act_buffer_top (
    input  logic              clk,
    input  logic              rst_n,
    input  act_pkg::gbf_wr_t  gbf_wr,
    input  act_pkg::act_len_t cfg_word,
    input  logic              cfg_val,
    input  logic              get_act,
    output act_pkg::act_out_t act,
    output logic              cfg_req,
    output logic              patch_done
);

    // ==============================
    // internal wiring
    // ==============================
    act_pkg::act_len_t  cfg_len;
    logic               patch_rst;
    logic               rd_en;
    act_pkg::act_addr_t rd_addr;
    act_pkg::act_word_t rd_data;
    logic               avail;

    // ==============================
    // control
    // ==============================
    act_cfg_regs cfg_regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_val  (cfg_val),
        .cfg_req  (cfg_req),
        .cfg_word (cfg_word),
        .cfg_len  (cfg_len)
    );

    act_patch_ctrl patch_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_val    (cfg_val),
        .cfg_len    (cfg_len),
        .get_act    (get_act),
        .act_rdy    (act.rdy),
        .cfg_req    (cfg_req),
        .patch_rst  (patch_rst),
        .patch_done (patch_done)
    );

    // ==============================
    // buffer and read path
    // ==============================
    act_gbf gbf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (gbf_wr),
        .patch_rst (patch_rst),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .avail     (avail)
    );

    act_fetch_unpack fetch_unpack_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .patch_rst (patch_rst),
        .avail     (avail),
        .rd_data   (rd_data),
        .get_act   (get_act),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .act       (act)
    );

endmodule

/* dv/act_sva.sv */
module act_sva (
    input logic              clk,
    input logic              rst_n,
    input act_pkg::gbf_wr_t  gbf_wr,
    input logic              get_act,
    input act_pkg::act_out_t act,
    input logic              cfg_req,
    input logic              patch_done,
    input logic              patch_rst,
    input logic              rd_en
);
    timeunit 1ns;
    timeprecision 1ps;

    import act_pkg::*;

    // unread words as the writer sees them
    int unread;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unread <= 0;
        end else if (patch_rst) begin
            unread <= gbf_wr.en ? 1 : 0;
        end else begin
            unread <= unread + int'(gbf_wr.en) - int'(rd_en);
        end
    end

    // ==============================
    // properties
    // ==============================

    // registered read, then load into the unpacker
    fetch_to_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> ##2 act.rdy)
        else $error("fetched word did not reach the output two cycles after rd_en");

    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (act.rdy && !get_act && !patch_rst) |=> (act.rdy && $stable(act.data)))
        else $error("activation output changed while the consumer was stalled");

    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        patch_done |=> (!patch_done && cfg_req))
        else $error("patch_done longer than one cycle or cfg_req did not follow");

    no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        gbf_wr.en |-> (unread < ACT_DEPTH))
        else $error("writer exceeded the buffer depth in unread words");

endmodule

bind act_buffer_top act_sva sva_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .gbf_wr     (gbf_wr),
    .get_act    (get_act),
    .act        (act),
    .cfg_req    (cfg_req),
    .patch_done (patch_done),
    .patch_rst  (patch_rst),
    .rd_en      (rd_en)
);

/* dv/act_tb.sv */
`include "act_settings.svh"

module act_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import act_pkg::*;

    // record: op nibble, 8-bit argument, one buffer word
    localparam int REC_W    = 12 + `ACT_PORT_WIDTH;
    localparam int MAX_RECS = 64;

    logic     clk;
    logic     rst_n;
    gbf_wr_t  gbf_wr;
    act_len_t cfg_word;
    logic     cfg_val;
    logic     get_act;
    act_out_t act;
    logic     cfg_req;
    logic     patch_done;

    logic [REC_W-1:0] recs [MAX_RECS];
    act_elem_t        exp_q [$];
    integer           seed = 32'h8b27_c744;
    int               n_recs;
    int               cycles = 0;
    int               cycle_limit = 0;
    int               done_seen = 0;
    int               done_expected = 0;

    act_buffer_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gbf_wr     (gbf_wr),
        .cfg_word   (cfg_word),
        .cfg_val    (cfg_val),
        .get_act    (get_act),
        .act        (act),
        .cfg_req    (cfg_req),
        .patch_done (patch_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ==============================
    // checks
    // ==============================
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_act(input act_elem_t got, input act_elem_t exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t ns: %s is %02h, expected %02h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t ns: patch_done is %b, expected %b",
                                      $time, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    // cycle budget and patch_done pulse count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            stop_with_error($sformatf("timeout: tests did not finish within %0d cycles",
                                      cycle_limit));
        end
    end

    always @(negedge clk) begin
        if (rst_n && patch_done) begin
            done_seen <= done_seen + 1;
        end
    end

    // ==============================
    // record actions
    // ==============================
    task automatic send_config(input act_len_t len);
        while (!cfg_req) begin
            @(negedge clk);
        end
        cfg_word = len;
        cfg_val  = 1'b1;
        @(negedge clk);
        cfg_val  = 1'b0;
    endtask

    task automatic write_word(input act_addr_t addr, input act_word_t data);
        gbf_wr.en   = 1'b1;
        gbf_wr.addr = addr;
        gbf_wr.data = data;
        // element 0 is the top byte
        for (int i = 0; i < ACT_ELEMS; i++) begin
            exp_q.push_back(data[`ACT_PORT_WIDTH-1-i*`ACT_DATA_WIDTH -: `ACT_DATA_WIDTH]);
        end
        @(negedge clk);
        gbf_wr.en = 1'b0;
    endtask

    task automatic pull_elems(input int count);
        act_elem_t held;
        int        gap;
        for (int n = 0; n < count; n++) begin
            while (!act.rdy) begin
                @(negedge clk);
            end
            held = act.data;
            gap  = $random(seed) & 3;
            // consumer stalls, output has to hold
            repeat (gap) begin
                @(negedge clk);
                check_level(act.rdy, 1'b1, "act.rdy while stalled");
                check_act(act.data, held, "act.data while stalled");
            end
            if (exp_q.size() == 0) begin
                stop_with_error("the DUT offered an element when none was expected");
            end
            check_act(act.data, exp_q.pop_front(), "act.data");
            get_act = 1'b1;
            @(negedge clk);
            get_act = 1'b0;
        end
    endtask

    task automatic expect_done();
        check_done(patch_done, 1'b1);
        if (exp_q.size() != 0) begin
            stop_with_error($sformatf("mismatch at %0t ns: patch ended with %0d elements left",
                                      $time, exp_q.size()));
        end
        @(negedge clk);
        check_done(patch_done, 1'b0);
        check_level(cfg_req, 1'b1, "cfg_req after patch_done");
        done_expected++;
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        logic [REC_W-1:0] rec;
        logic [3:0]       op;
        logic [7:0]       arg;
        act_word_t        word;

        rst_n    = 1'b0;
        gbf_wr   = '0;
        cfg_word = '0;
        cfg_val  = 1'b0;
        get_act  = 1'b0;

        $readmemh("dv/act_tests.dat", recs);
        n_recs = 0;
        while (n_recs < MAX_RECS && recs[n_recs][REC_W-1 -: 4] != 4'h0) begin
            n_recs++;
        end
        if (n_recs == 0) begin
            stop_with_error("the data file holds no test records");
        end
        cycle_limit = n_recs * 64;

        repeat (2) @(negedge clk);
        check_level(act.rdy, 1'b0, "act.rdy in reset");
        check_done(patch_done, 1'b0);
        check_level(cfg_req, 1'b0, "cfg_req in reset");
        rst_n = 1'b1;
        @(negedge clk);
        check_level(cfg_req, 1'b1, "cfg_req after reset");
        check_level(act.rdy, 1'b0, "act.rdy after reset");
        check_done(patch_done, 1'b0);

        for (int r = 0; r < n_recs; r++) begin
            rec  = recs[r];
            op   = rec[REC_W-1 -: 4];
            arg  = rec[REC_W-5 -: 8];
            word = rec[`ACT_PORT_WIDTH-1:0];
            case (op)
                4'h1: send_config(act_len_t'(arg));
                4'h2: write_word(act_addr_t'(arg), word);
                4'h3: pull_elems(int'(arg));
                4'h4: expect_done();
                default: stop_with_error($sformatf("record %0d has unknown op %0h", r, op));
            endcase
        end

        if (done_seen == done_expected && exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("mismatch at %0t ns: %0d patch_done pulses for %0d patches",
                     $time, done_seen, done_expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation stopped at the end check");
        end
    end

endmodule

/* dv/act_tests.dat */
// columns: op (1 digit), arg (2 digits), word (16 digits), all hex
// op 1 config (arg = length in words), 2 write (arg = address),
// op 3 pull (arg = element count), 4 expect patch_done, 0 ends the list
1030000000000000000 // patch 1, three words
2000011223344556677
20188a9b8c7d6e5f403
3060000000000000000 // part of the first word
202deadbeefcafe0102 // written while pulling
3120000000000000000 // remaining 18 elements
4000000000000000000
1020000000000000000 // patch 2, two words from address 0
200f0e1d2c3b4a59687
2017f6e5d4c3b2a1908
3050000000000000000
30b0000000000000000
4000000000000000000
0000000000000000000

/* project.f */
+incdir+source
source/act_pkg.sv
source/act_cfg_regs.sv
source/act_patch_ctrl.sv
source/act_gbf.sv
source/act_fetch_unpack.sv
source/act_buffer_top.sv
dv/act_sva.sv
dv/act_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= act_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
